//--- Makefile
# Verilator build and run for the execute stage testbench.

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing
TOP      = tb_ex_stage
RTL_TOP  = ex_stage
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- alu_ex.sv
/*
 * Combinational ALU of the execute stage. Single cycle results,
 * CLO/CLZ, first multiply stage, divider control and stall request.
 */

`timescale 1ns/1ps
`default_nettype none
`include "ex_defines.svh"

module alu_ex (
    input  wire alu_pkg::aluop_e         aluop,
    input  wire [`EX_WORD_W-1:0]         opr1,
    input  wire [`EX_WORD_W-1:0]         opr2,
    input  wire                          div_ready,
    output logic                         div_start,
    output logic                         div_signed,
    output logic [`EX_WORD_W-1:0]        alures,
    output logic                         resnrdy,
    output muldiv_pkg::mul_part_s        mul_part,
    output logic                         stallreq
);

    localparam int W = `EX_WORD_W;
    localparam int H = W / 2;

    logic [W-1:0]        abs_opr1;
    logic [W-1:0]        abs_opr2;
    logic [W-1:0]        clz_opr;
    logic [15:0]         clz_p16;
    logic [7:0]          clz_p8;
    logic [3:0]          clz_p4;
    logic                z16;
    logic                z8;
    logic                z4;
    logic [1:0]          clz_lo;
    logic [W-1:0]        clz_res;
    alu_pkg::mul_mode_e  mul_mode;
    logic [W-1:0]        mopr1;
    logic [W-1:0]        mopr2;

    assign abs_opr1 = opr1[W-1] ? -opr1 : opr1;
    assign abs_opr2 = opr2[W-1] ? -opr2 : opr2;

    // ******************************************************************
    // count leading ones/zeros
    // ******************************************************************

    // CLO is CLZ of the inverted operand.
    always_comb begin
        clz_opr = (aluop == alu_pkg::ALU_CLO) ? ~opr1 : opr1;
        // halve the search window at each step.
        z16     = (clz_opr[31:16] == 16'b0);
        clz_p16 = z16 ? clz_opr[15:0] : clz_opr[31:16];
        z8      = (clz_p16[15:8] == 8'b0);
        clz_p8  = z8 ? clz_p16[7:0] : clz_p16[15:8];
        z4      = (clz_p8[7:4] == 4'b0);
        clz_p4  = z4 ? clz_p8[3:0] : clz_p8[7:4];
        casez (clz_p4)
            4'b1???: clz_lo = 2'd0;
            4'b01??: clz_lo = 2'd1;
            4'b001?: clz_lo = 2'd2;
            default: clz_lo = 2'd3;
        endcase
        if (clz_opr == '0) begin
            clz_res = 32'd32;
        end else begin
            clz_res = {27'b0, z16, z8, z4, clz_lo};
        end
    end

    // ******************************************************************
    // multiply, first stage
    // ******************************************************************

    always_comb begin
        case (aluop)
            alu_pkg::ALU_MUL,
            alu_pkg::ALU_MULT,
            alu_pkg::ALU_MADD,
            alu_pkg::ALU_MSUB:  mul_mode = alu_pkg::MUL_SIGNED;
            alu_pkg::ALU_MULTU,
            alu_pkg::ALU_MADDU,
            alu_pkg::ALU_MSUBU: mul_mode = alu_pkg::MUL_UNSIGNED;
            default:            mul_mode = alu_pkg::MUL_NONE;
        endcase
    end

    // signed forms multiply magnitudes and hilo_unit fixes the sign.
    always_comb begin
        case (mul_mode)
            alu_pkg::MUL_SIGNED: begin
                mopr1         = abs_opr1;
                mopr2         = abs_opr2;
                mul_part.sign = opr1[W-1] ^ opr2[W-1];
            end
            alu_pkg::MUL_UNSIGNED: begin
                mopr1         = opr1;
                mopr2         = opr2;
                mul_part.sign = 1'b0;
            end
            default: begin
                mopr1         = '0;
                mopr2         = '0;
                mul_part.sign = 1'b0;
            end
        endcase
        mul_part.ll = mopr1[H-1:0] * mopr2[H-1:0];
        mul_part.hl = mopr1[W-1:H] * mopr2[H-1:0];
        mul_part.lh = mopr1[H-1:0] * mopr2[W-1:H];
        mul_part.hh = mopr1[W-1:H] * mopr2[W-1:H];
    end

    // ******************************************************************
    // divider control
    // ******************************************************************

    // start stays up until the divider reports ready.
    always_comb begin
        div_start  = 1'b0;
        div_signed = 1'b0;
        case (aluop)
            alu_pkg::ALU_DIV: begin
                div_start  = !div_ready;
                div_signed = 1'b1;
            end
            alu_pkg::ALU_DIVU: begin
                div_start  = !div_ready;
            end
            default: ;
        endcase
    end

    assign stallreq = div_start;

    always_comb begin
        case (aluop)
            alu_pkg::ALU_SLL:  alures = opr2 << opr1[4:0];
            alu_pkg::ALU_SRL:  alures = opr2 >> opr1[4:0];
            alu_pkg::ALU_SRA:  alures = $signed(opr2) >>> opr1[4:0];
            alu_pkg::ALU_ADD,
            alu_pkg::ALU_ADDU: alures = opr1 + opr2;
            alu_pkg::ALU_SUB,
            alu_pkg::ALU_SUBU: alures = opr1 - opr2;
            alu_pkg::ALU_AND:  alures = opr1 & opr2;
            alu_pkg::ALU_OR:   alures = opr1 | opr2;
            alu_pkg::ALU_XOR:  alures = opr1 ^ opr2;
            alu_pkg::ALU_NOR:  alures = ~(opr1 | opr2);
            alu_pkg::ALU_SLT:  alures = {{(W-1){1'b0}}, $signed(opr1) < $signed(opr2)};
            alu_pkg::ALU_SLTU: alures = {{(W-1){1'b0}}, opr1 < opr2};
            alu_pkg::ALU_MOV,
            alu_pkg::ALU_MTHI,
            alu_pkg::ALU_MTLO: alures = opr1;
            alu_pkg::ALU_CLO,
            alu_pkg::ALU_CLZ:  alures = clz_res;
            default:           alures = '0;
        endcase
    end

    // result comes from late_res one cycle later.
    assign resnrdy = (aluop == alu_pkg::ALU_MFHI) ||
                     (aluop == alu_pkg::ALU_MFLO) ||
                     (aluop == alu_pkg::ALU_MUL);

    // ready only answers a divide held through the stall.
    always_comb begin
        if (div_ready) begin
            a_ready_div: assert final (aluop inside {alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU});
        end
    end

endmodule

`default_nettype wire

//--- alu_pkg.sv
/*
 * ALU opcode encoding and the opcode-class helper types
 * used to steer the multiplier and the HI/LO accumulator.
 */

`default_nettype none
`include "ex_defines.svh"

package alu_pkg;

    // operation issued to the execute stage.
    typedef enum logic [`EX_ALUOP_W-1:0] {
        ALU_NOP,   ALU_SLL,   ALU_SRL,   ALU_SRA,
        ALU_ADD,   ALU_ADDU,  ALU_SUB,   ALU_SUBU,
        ALU_AND,   ALU_OR,    ALU_XOR,   ALU_NOR,
        ALU_SLT,   ALU_SLTU,  ALU_MOV,   ALU_MTHI,
        ALU_MTLO,  ALU_MFHI,  ALU_MFLO,  ALU_CLO,
        ALU_CLZ,   ALU_MUL,   ALU_MULT,  ALU_MULTU,
        ALU_MADD,  ALU_MADDU, ALU_MSUB,  ALU_MSUBU,
        ALU_DIV,   ALU_DIVU
    } aluop_e;

    // operand treatment for the first multiply stage.
    typedef enum logic [1:0] {
        MUL_NONE,
        MUL_SIGNED,
        MUL_UNSIGNED
    } mul_mode_e;

    // how the finished product lands in HI/LO.
    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_SET,
        ACC_ADD,
        ACC_SUB
    } acc_mode_e;

endpackage

`default_nettype wire

//--- div_iter.sv
/*
 * Iterative restoring divider, one quotient bit per cycle.
 * Signed and unsigned modes, result sign fixed on the last step.
 */

`timescale 1ns/1ps
`default_nettype none
`include "ex_defines.svh"

module div_iter (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire                          is_signed,
    input  wire [`EX_WORD_W-1:0]         dividend,
    input  wire [`EX_WORD_W-1:0]         divisor,
    output logic                         ready,
    output muldiv_pkg::div_res_s         res
);

    localparam int W     = `EX_WORD_W;
    localparam int CNT_W = $clog2(W);

    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic              last;
    logic              dvd_neg;
    logic              dvs_neg;
    logic [W-1:0]      rem_q;
    logic [W-1:0]      quo_q;
    logic [W-1:0]      dvs_q;
    logic              quo_neg;
    logic              rem_neg;
    logic [W:0]        shifted;
    logic [W:0]        diff;
    logic [W-1:0]      rem_n;
    logic [W-1:0]      quo_n;

    assign dvd_neg = is_signed & dividend[W-1];
    assign dvs_neg = is_signed & divisor[W-1];
    assign last    = busy && (cnt == CNT_W'(W - 1));

    // one restoring step, dividend bits shift out of quo_q.
    always_comb begin
        shifted = {rem_q, quo_q[W-1]};
        diff    = shifted - {1'b0, dvs_q};
        if (diff[W]) begin
            rem_n = shifted[W-1:0];
            quo_n = {quo_q[W-2:0], 1'b0};
        end else begin
            rem_n = diff[W-1:0];
            quo_n = {quo_q[W-2:0], 1'b1};
        end
    end

    // ******************************************************************
    // control
    // ******************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            ready <= last;
            if (!busy && start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // quotient truncates toward zero, remainder follows the dividend.
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            rem_q   <= '0;
            quo_q   <= dvd_neg ? -dividend : dividend;
            dvs_q   <= dvs_neg ? -divisor : divisor;
            quo_neg <= dvd_neg ^ dvs_neg;
            rem_neg <= dvd_neg;
        end else if (busy) begin
            rem_q <= rem_n;
            quo_q <= quo_n;
        end
        if (last) begin
            res.quot <= quo_neg ? -quo_n : quo_n;
            res.rem  <= rem_neg ? -rem_n : rem_n;
        end
    end

    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                    ready |=> !ready);

endmodule

`default_nettype wire

//--- ex_defines.svh
/*
 * Shared widths for the MIPS32 execute stage.
 * Data word, HI/LO pair and ALU opcode field.
 */

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// ******************************************************************
// datapath widths
// ******************************************************************

// one general purpose register word.
`define EX_WORD_W   32

// HI/LO pair, also the full product width.
`define EX_DWORD_W  64

// encoded ALU operation from decode.
`define EX_ALUOP_W  5

`endif

//--- ex_stage.sv
/*
 * Execute stage top level.
 * Joins the ALU, the HI/LO unit and the iterative divider.
 */

`timescale 1ns/1ps
`default_nettype none
`include "ex_defines.svh"

module ex_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire alu_pkg::aluop_e         aluop,
    input  wire [`EX_WORD_W-1:0]         opr1,
    input  wire [`EX_WORD_W-1:0]         opr2,
    output wire [`EX_WORD_W-1:0]         alures,
    output wire                          resnrdy,
    output wire                          stallreq,
    output wire [`EX_WORD_W-1:0]         late_res,
    output wire muldiv_pkg::hilo_u       hilo
);

    wire muldiv_pkg::mul_part_s  mul_part;
    wire muldiv_pkg::div_res_s   div_res;
    wire                         div_start;
    wire                         div_signed;
    wire                         div_ready;

    alu_ex u_alu_ex (
        .aluop      (aluop),
        .opr1       (opr1),
        .opr2       (opr2),
        .div_ready  (div_ready),
        .div_start  (div_start),
        .div_signed (div_signed),
        .alures     (alures),
        .resnrdy    (resnrdy),
        .mul_part   (mul_part),
        .stallreq   (stallreq)
    );

    hilo_unit u_hilo_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .aluop      (aluop),
        .opr1       (opr1),
        .mul_part   (mul_part),
        .div_ready  (div_ready),
        .div_res    (div_res),
        .hilo       (hilo),
        .late_res   (late_res)
    );

    // operands stay on opr1/opr2 for the whole stall.
    div_iter u_div_iter (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (div_start),
        .is_signed  (div_signed),
        .dividend   (opr1),
        .divisor    (opr2),
        .ready      (div_ready),
        .res        (div_res)
    );

endmodule

`default_nettype wire

//--- hilo_unit.sv
/*
 * HI/LO owner. Finishes the multiply from the partial products,
 * accumulates MADD/MSUB, loads divide results and MTHI/MTLO,
 * and registers the late result for MUL/MFHI/MFLO.
 */

`timescale 1ns/1ps
`default_nettype none
`include "ex_defines.svh"

module hilo_unit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire alu_pkg::aluop_e         aluop,
    input  wire [`EX_WORD_W-1:0]         opr1,
    input  wire muldiv_pkg::mul_part_s   mul_part,
    input  wire                          div_ready,
    input  wire muldiv_pkg::div_res_s    div_res,
    output muldiv_pkg::hilo_u            hilo,
    output logic [`EX_WORD_W-1:0]        late_res
);

    localparam int W  = `EX_WORD_W;
    localparam int DW = `EX_DWORD_W;
    localparam int H  = W / 2;

    logic [DW-1:0]       prod_mag;
    logic [DW-1:0]       prod;
    alu_pkg::acc_mode_e  acc_mode;
    logic                mul_class;

    // second multiply stage, magnitude then sign.
    always_comb begin
        prod_mag = {{W{1'b0}}, mul_part.ll}
                 + ({{W{1'b0}}, mul_part.hl} << H)
                 + ({{W{1'b0}}, mul_part.lh} << H)
                 + {mul_part.hh, {W{1'b0}}};
        prod = mul_part.sign ? -prod_mag : prod_mag;
    end

    always_comb begin
        case (aluop)
            alu_pkg::ALU_MULT,
            alu_pkg::ALU_MULTU: acc_mode = alu_pkg::ACC_SET;
            alu_pkg::ALU_MADD,
            alu_pkg::ALU_MADDU: acc_mode = alu_pkg::ACC_ADD;
            alu_pkg::ALU_MSUB,
            alu_pkg::ALU_MSUBU: acc_mode = alu_pkg::ACC_SUB;
            default:            acc_mode = alu_pkg::ACC_NONE;
        endcase
    end

    // ******************************************************************
    // HI/LO register
    // ******************************************************************

    // divide result: remainder to HI, quotient to LO.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hilo <= '0;
        end else if (div_ready) begin
            hilo.pair.hi <= div_res.rem;
            hilo.pair.lo <= div_res.quot;
        end else begin
            case (acc_mode)
                alu_pkg::ACC_SET: hilo.dword <= prod;
                alu_pkg::ACC_ADD: hilo.dword <= hilo.dword + prod;
                alu_pkg::ACC_SUB: hilo.dword <= hilo.dword - prod;
                default: begin
                    if (aluop == alu_pkg::ALU_MTHI) begin
                        hilo.pair.hi <= opr1;
                    end else if (aluop == alu_pkg::ALU_MTLO) begin
                        hilo.pair.lo <= opr1;
                    end
                end
            endcase
        end
    end

    // late result, valid the cycle after the opcode.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            late_res <= '0;
        end else begin
            case (aluop)
                alu_pkg::ALU_MUL:  late_res <= prod[W-1:0];
                alu_pkg::ALU_MFHI: late_res <= hilo.pair.hi;
                alu_pkg::ALU_MFLO: late_res <= hilo.pair.lo;
                default: ;
            endcase
        end
    end

    assign mul_class = (acc_mode != alu_pkg::ACC_NONE) || (aluop == alu_pkg::ALU_MUL);

    // divider write and a multiply never compete for HI/LO.
    a_div_no_mul: assert property (@(posedge clk) disable iff (!rst_n)
                                   div_ready |-> !mul_class);

endmodule

`default_nettype wire

//--- list.f
+incdir+.
alu_pkg.sv
muldiv_pkg.sv
alu_ex.sv
div_iter.sv
hilo_unit.sv
ex_stage.sv
tb_ex_stage.sv

//--- muldiv_pkg.sv
/*
 * Multiply and divide data types: split partial products,
 * divider result and the HI/LO pair with its two views.
 */

`default_nettype none
`include "ex_defines.svh"

package muldiv_pkg;

    // 16x16 partial products of the operand magnitudes.
    // naming is <opr1 half><opr2 half>.
    typedef struct packed {
        logic [`EX_WORD_W-1:0] ll;
        logic [`EX_WORD_W-1:0] hl;
        logic [`EX_WORD_W-1:0] lh;
        logic [`EX_WORD_W-1:0] hh;
        logic                  sign;
    } mul_part_s;

    // sign corrected divider output.
    typedef struct packed {
        logic [`EX_WORD_W-1:0] quot;
        logic [`EX_WORD_W-1:0] rem;
    } div_res_s;

    typedef struct packed {
        logic [`EX_WORD_W-1:0] hi;
        logic [`EX_WORD_W-1:0] lo;
    } hilo_pair_s;

    // HI/LO as two registers or as one accumulator.
    typedef union packed {
        hilo_pair_s             pair;
        logic [`EX_DWORD_W-1:0] dword;
    } hilo_u;

endpackage

`default_nettype wire

//--- tb_ex_stage.sv
/*
 * Directed testbench for the execute stage.
 * Clock, reset, reference models, test tasks and watchdog.
 */

`timescale 1ns/1ps
`default_nettype none
`include "ex_defines.svh"

module tb_ex_stage;

    localparam int W          = `EX_WORD_W;
    localparam int N_RAND     = 20;
    localparam int N_DIV      = 16;
    localparam int DIV_CYCLES = 33;
    localparam int N_OPS      = 16 + 14 * N_RAND + 2 * (N_RAND + 2) + 6 * N_RAND
                              + 4 * N_RAND + 3 + 2 * N_DIV + 3 * N_RAND;

    logic                    clk;
    logic                    rst_n;
    alu_pkg::aluop_e         aluop;
    logic [W-1:0]            opr1;
    logic [W-1:0]            opr2;
    wire  [W-1:0]            alures;
    wire                     resnrdy;
    wire                     stallreq;
    wire  [W-1:0]            late_res;
    wire muldiv_pkg::hilo_u  hilo;
    logic [63:0]             model_hilo;

    ex_stage DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .aluop    (aluop),
        .opr1     (opr1),
        .opr2     (opr2),
        .alures   (alures),
        .resnrdy  (resnrdy),
        .stallreq (stallreq),
        .late_res (late_res),
        .hilo     (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ******************************************************************
    // reference models and helpers
    // ******************************************************************

    function automatic logic [W-1:0] alu_model(input alu_pkg::aluop_e op,
                                               input logic [W-1:0] a, input logic [W-1:0] b);
        logic [4:0]   sh;
        logic [W-1:0] fill;
        sh   = a[4:0];
        // sign bits shifted in from the left.
        fill = b[W-1] ? ~({W{1'b1}} >> sh) : '0;
        case (op)
            alu_pkg::ALU_SLL:  return b << sh;
            alu_pkg::ALU_SRL:  return b >> sh;
            alu_pkg::ALU_SRA:  return (b >> sh) | fill;
            alu_pkg::ALU_ADD,
            alu_pkg::ALU_ADDU: return a + b;
            alu_pkg::ALU_SUB,
            alu_pkg::ALU_SUBU: return a - b;
            alu_pkg::ALU_AND:  return a & b;
            alu_pkg::ALU_OR:   return a | b;
            alu_pkg::ALU_XOR:  return a ^ b;
            alu_pkg::ALU_NOR:  return ~(a | b);
            alu_pkg::ALU_SLT:  return (a[W-1] != b[W-1]) ? W'(a[W-1]) : W'(a < b);
            alu_pkg::ALU_SLTU: return W'(a < b);
            alu_pkg::ALU_MOV:  return a;
            default:           return '0;
        endcase
    endfunction

    // number of leading bits equal to b.
    function automatic logic [W-1:0] lead_count(input logic [W-1:0] v, input logic b);
        int n;
        n = 0;
        while (n < W && v[W-1-n] == b) begin
            n++;
        end
        return W'(n);
    endfunction

    function automatic logic [63:0] product(input logic [W-1:0] a, input logic [W-1:0] b,
                                            input logic sgn);
        logic [63:0] ea;
        logic [63:0] eb;
        ea = sgn ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
        eb = sgn ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
        return ea * eb;
    endfunction

    task automatic check_val(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopping on first error");
        end
    endtask

    // drive one opcode and return once the combinational outputs settled.
    task automatic apply(input alu_pkg::aluop_e op, input logic [W-1:0] a,
                         input logic [W-1:0] b);
        @(posedge clk);
        #2;
        aluop = op;
        opr1  = a;
        opr2  = b;
        #1;
    endtask

    // ******************************************************************
    // tests
    // ******************************************************************

    task automatic single_cycle_results();
        alu_pkg::aluop_e ops [14] = '{alu_pkg::ALU_SLL, alu_pkg::ALU_SRL, alu_pkg::ALU_SRA,
            alu_pkg::ALU_ADD, alu_pkg::ALU_ADDU, alu_pkg::ALU_SUB, alu_pkg::ALU_SUBU,
            alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR, alu_pkg::ALU_NOR,
            alu_pkg::ALU_SLT, alu_pkg::ALU_SLTU, alu_pkg::ALU_MOV};
        logic [W-1:0] a;
        logic [W-1:0] b;
        foreach (ops[i]) begin
            for (int j = 0; j < N_RAND; j++) begin
                a = $urandom;
                b = $urandom;
                apply(ops[i], a, b);
                check_val({ops[i].name(), " alures"}, alures, alu_model(ops[i], a, b));
                check_val("single cycle resnrdy", resnrdy, 0);
                check_val("single cycle stallreq", stallreq, 0);
                check_val("hilo untouched", hilo.dword, model_hilo);
            end
        end
    endtask

    task automatic clo_clz_counts();
        logic [W-1:0] v;
        for (int j = 0; j < N_RAND + 2; j++) begin
            if (j == 0) begin
                v = '0;
            end else if (j == 1) begin
                v = '1;
            end else begin
                v = $urandom >> ($urandom % W);
            end
            apply(alu_pkg::ALU_CLZ, v, '0);
            check_val("CLZ", alures, lead_count(v, 1'b0));
            apply(alu_pkg::ALU_CLO, ~v, '0);
            check_val("CLO", alures, lead_count(~v, 1'b1));
        end
    endtask

    task automatic multiply_products();
        logic [W-1:0] a;
        logic [W-1:0] b;
        for (int j = 0; j < N_RAND; j++) begin
            a = $urandom;
            b = $urandom;
            apply(alu_pkg::ALU_MULT, a, b);
            model_hilo = product(a, b, 1'b1);
            apply(alu_pkg::ALU_NOP, '0, '0);
            check_val("MULT hilo", hilo.dword, model_hilo);
            apply(alu_pkg::ALU_MULTU, a, b);
            model_hilo = product(a, b, 1'b0);
            apply(alu_pkg::ALU_NOP, '0, '0);
            check_val("MULTU hilo", hilo.dword, model_hilo);
            apply(alu_pkg::ALU_MUL, a, b);
            check_val("MUL resnrdy", resnrdy, 1);
            check_val("MUL stallreq", stallreq, 0);
            apply(alu_pkg::ALU_NOP, '0, '0);
            check_val("MUL late_res", late_res, product(a, b, 1'b1) & 64'hffff_ffff);
            check_val("MUL keeps hilo", hilo.dword, model_hilo);
        end
    endtask

    task automatic madd_msub_accumulate();
        alu_pkg::aluop_e acc_ops [4] = '{alu_pkg::ALU_MADD, alu_pkg::ALU_MADDU,
                                         alu_pkg::ALU_MSUB, alu_pkg::ALU_MSUBU};
        alu_pkg::aluop_e op;
        logic [W-1:0]    a;
        logic [W-1:0]    b;
        logic [63:0]     p;
        a = $urandom;
        b = $urandom;
        apply(alu_pkg::ALU_MTHI, a, '0);
        apply(alu_pkg::ALU_MTLO, b, '0);
        model_hilo = {a, b};
        // back to back so each check sees the previous opcode's write.
        for (int j = 0; j < 4 * N_RAND; j++) begin
            op = acc_ops[j % 4];
            a  = $urandom;
            b  = $urandom;
            apply(op, a, b);
            check_val("accumulate hilo", hilo.dword, model_hilo);
            p = product(a, b, op == alu_pkg::ALU_MADD || op == alu_pkg::ALU_MSUB);
            if (op == alu_pkg::ALU_MADD || op == alu_pkg::ALU_MADDU) begin
                model_hilo = model_hilo + p;
            end else begin
                model_hilo = model_hilo - p;
            end
        end
        apply(alu_pkg::ALU_NOP, '0, '0);
        check_val("final accumulate hilo", hilo.dword, model_hilo);
    endtask

    task automatic divide_with_stall();
        logic [W-1:0]        a;
        logic [W-1:0]        b;
        logic signed [W-1:0] sa;
        logic signed [W-1:0] sb;
        logic [W-1:0]        q;
        logic [W-1:0]        r;
        logic                sgn;
        int                  cycles;
        for (int j = 0; j < N_DIV; j++) begin
            sgn = j[0];
            a   = $urandom;
            b   = $urandom >> ($urandom % W);
            if ($urandom % 2) begin
                b = -b;
            end
            if (b == '0) begin
                b = 1;
            end
            // the one signed quotient that does not fit.
            if (sgn && a == 32'h8000_0000 && b == '1) begin
                b = 32'hffff_fffe;
            end
            apply(sgn ? alu_pkg::ALU_DIV : alu_pkg::ALU_DIVU, a, b);
            check_val("DIV stallreq raised", stallreq, 1);
            cycles = 0;
            while (stallreq && cycles <= DIV_CYCLES + 4) begin
                @(posedge clk);
                #3;
                cycles++;
            end
            check_val("DIV stall length", 64'(cycles), DIV_CYCLES);
            sa = a;
            sb = b;
            if (sgn) begin
                q = sa / sb;
                r = sa % sb;
            end else begin
                q = a / b;
                r = a % b;
            end
            model_hilo = {r, q};
            apply(alu_pkg::ALU_NOP, '0, '0);
            check_val(sgn ? "DIV hilo" : "DIVU hilo", hilo.dword, model_hilo);
        end
    endtask

    task automatic move_from_hilo();
        logic [W-1:0] v;
        logic         use_hi;
        for (int j = 0; j < N_RAND; j++) begin
            v      = $urandom;
            use_hi = j[0];
            if (use_hi) begin
                apply(alu_pkg::ALU_MTHI, v, '0);
                model_hilo[63:32] = v;
                apply(alu_pkg::ALU_MFHI, '0, '0);
            end else begin
                apply(alu_pkg::ALU_MTLO, v, '0);
                model_hilo[31:0] = v;
                apply(alu_pkg::ALU_MFLO, '0, '0);
            end
            check_val("MFHI/MFLO resnrdy", resnrdy, 1);
            apply(alu_pkg::ALU_NOP, '0, '0);
            check_val("MFHI/MFLO late_res", late_res,
                      use_hi ? model_hilo[63:32] : model_hilo[31:0]);
        end
    endtask

    // ******************************************************************
    // main sequence and watchdog
    // ******************************************************************

    initial begin
        // seed the generator once.
        void'($urandom(32'hcf61));
        rst_n      = 1'b0;
        aluop      = alu_pkg::ALU_NOP;
        opr1       = '0;
        opr2       = '0;
        model_hilo = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        #1;
        check_val("hilo after reset", hilo.dword, 0);
        check_val("late_res after reset", late_res, 0);
        single_cycle_results();
        clo_clz_counts();
        multiply_products();
        madd_msub_accumulate();
        divide_with_stall();
        move_from_hilo();
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(longint'(N_OPS) * 40 * 20);
        $display("timeout: the tests did not finish in the expected time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
